//--- design/axil_display_regs.sv
/* AXI4-Lite register block for the display driver
   holds the packed digit nibbles and the enable bit, and performs shift-in pushes */
`timescale 1ns/10ps
`default_nettype none

module axil_display_regs import seg_pkg::*; #(
	parameter int num_digits = 4 // 1 to 8 digits
) (
	input  wire                      CLK,
	input  wire                      reset,
	// write address and data
	input  wire  [3:0]               awaddr,
	input  wire                      awvalid,
	output logic                     awready,
	input  wire  [31:0]              wdata,
	input  wire  [3:0]               wstrb, // ignored as every write is a full word
	input  wire                      wvalid,
	output logic                     wready,
	// write response
	output logic [1:0]               bresp,
	output logic                     bvalid,
	input  wire                      bready,
	// read address and data
	input  wire  [3:0]               araddr,
	input  wire                      arvalid,
	output logic                     arready,
	output logic [31:0]              rdata,
	output logic [1:0]               rresp,
	output logic                     rvalid,
	input  wire                      rready,
	// display state
	output logic [4*num_digits-1:0]  digits, // digit k in bits 4k+3:4k
	output logic                     enable
);

	localparam int digit_width = 4 * num_digits;

	logic                   wr_fire; // aw and w accepted this cycle
	logic                   rd_fire; // ar accepted this cycle
	logic                   wr_known; // write address decodes to a register
	logic                   rd_known; // read address decodes to a register
	logic [31:0]            rd_value; // read data before the output register
	logic [digit_width+3:0] push_value; // digits with the new nibble appended low

	// both channels are taken together, only while no response waits
	assign awready = awvalid && wvalid && !bvalid;
	assign wready = awready;
	assign wr_fire = awready; // already includes both valids

	assign arready = !rvalid; // one read in flight at most
	assign rd_fire = arvalid && arready;

	assign push_value = {digits, wdata[3:0]}; // top digit falls off when truncated

	always_comb begin
		case (awaddr)
			addr_digits, addr_control, addr_push: wr_known = 1'b1;
			default: wr_known = 1'b0;
		endcase
	end

	always_comb begin
		rd_value = '0;
		rd_known = 1'b1;
		case (araddr)
			addr_digits: rd_value[digit_width-1:0] = digits;
			addr_control: rd_value[0] = enable;
			addr_push: rd_value = '0; // write-only push port reads as zero
			default: rd_known = 1'b0;
		endcase
	end

	// register updates land with bvalid, the cycle after the handshake
	always_ff @(posedge CLK) begin
		if (reset) begin
			digits <= '0;
			enable <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			if (wr_fire) begin
				bvalid <= 1'b1;
				case (awaddr)
					addr_digits: digits <= wdata[digit_width-1:0];
					addr_control: enable <= wdata[0];
					addr_push: digits <= push_value[digit_width-1:0]; // shift up one nibble
					default: ; // unknown offset leaves state alone
				endcase
			end else if (bvalid && bready) begin
				bvalid <= 1'b0; // response taken
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (wr_fire) begin
			bresp <= wr_known ? resp_okay : resp_slverr;
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			rvalid <= 1'b0;
		end else begin
			if (rd_fire) begin
				rvalid <= 1'b1;
			end else if (rvalid && rready) begin
				rvalid <= 1'b0; // data taken
			end
		end
	end

	// read payload held with rvalid until rready
	always_ff @(posedge CLK) begin
		if (rd_fire) begin
			rdata <= rd_value;
			rresp <= rd_known ? resp_okay : resp_slverr;
		end
	end

endmodule

`default_nettype wire

//--- design/digit_scanner.sv
/* digit scanner with tick prescaler and one-hot anode select
   steps to the next digit at each slot end and latches that digit's segment pattern */
`timescale 1ns/10ps
`default_nettype none

module digit_scanner import seg_pkg::*; #(
	parameter int num_digits = 4, // 1 to 8
	parameter int tick_log2 = 3 // tick period is 2**tick_log2 cycles
) (
	input  wire                      CLK,
	input  wire                      reset,
	input  wire  [4*num_digits-1:0]  digits, // packed hex nibbles
	input  wire                      enable,
	input  wire                      slot_done, // end of the current digit slot
	output logic                     tick, // one cycle pulse per prescaler wrap
	output logic [seg_count-1:0]     pattern, // active low pattern of the shown digit
	output logic [num_digits-1:0]    anodes // active high, one-hot or zero
);

	localparam int idx_width = (num_digits > 1) ? $clog2(num_digits) : 1;
	localparam logic [idx_width-1:0] last_digit = idx_width'(num_digits - 1);
	localparam logic [num_digits-1:0] first_anode = num_digits'(1);

	logic [tick_log2-1:0]  prescale; // free running
	logic [idx_width-1:0]  digit_index; // digit being shown
	logic [idx_width-1:0]  next_index; // digit of the coming slot
	logic [3:0]            next_nibble; // hex value of that digit
	logic [num_digits-1:0] anode_sel; // one-hot select before enable gating

	always_ff @(posedge CLK) begin
		if (reset) begin
			prescale <= '0;
		end else begin
			prescale <= prescale + 1'b1; // keeps counting with display off
		end
	end

	assign tick = &prescale; // last count of each period

	// wrap from the highest digit back to digit 0
	assign next_index = (digit_index == last_digit) ? '0 : digit_index + 1'b1;
	assign next_nibble = digits[next_index*4 +: 4];

	// digit, anode and pattern all change on the same edge
	always_ff @(posedge CLK) begin
		if (reset) begin
			digit_index <= '0;
			anode_sel <= first_anode; // digit 0 first
			pattern <= seg_blank; // dark until the first slot end
		end else begin
			if (slot_done) begin
				digit_index <= next_index;
				anode_sel <= first_anode << next_index;
				pattern <= hex_to_segments(next_nibble); // sampled once per slot
			end
		end
	end

	assign anodes = anode_sel & {num_digits{enable}}; // all off while disabled

endmodule

`default_nettype wire

//--- design/seg_display_top.sv
/* top level of the AXI4-Lite seven-segment display driver
   sets the digit count and tick rate and connects register block, scanner and sequencer */
`timescale 1ns/10ps
`default_nettype none

module seg_display_top import seg_pkg::*; #(
	parameter int num_digits = 4,
	parameter int tick_log2 = 3
) (
	input  wire                    CLK,
	input  wire                    reset,
	input  wire  [3:0]             awaddr,
	input  wire                    awvalid,
	output logic                   awready,
	input  wire  [31:0]            wdata,
	input  wire  [3:0]             wstrb, // ignored by the register block
	input  wire                    wvalid,
	output logic                   wready,
	output logic [1:0]             bresp,
	output logic                   bvalid,
	input  wire                    bready,
	input  wire  [3:0]             araddr,
	input  wire                    arvalid,
	output logic                   arready,
	output logic [31:0]            rdata,
	output logic [1:0]             rresp,
	output logic                   rvalid,
	input  wire                    rready,
	output logic [num_digits-1:0]  anodes, // active high
	output logic [seg_count-1:0]   segments // active low, a in msb
);

	logic [4*num_digits-1:0] digits;
	logic                    enable;
	logic                    tick;
	logic [seg_count-1:0]    pattern;
	logic                    slot_done;

	axil_display_regs #(.num_digits(num_digits)) regs (
		.CLK(CLK), .reset(reset),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.digits(digits), .enable(enable)
	);

	digit_scanner #(.num_digits(num_digits), .tick_log2(tick_log2)) scanner (
		.CLK(CLK), .reset(reset),
		.digits(digits), .enable(enable), .slot_done(slot_done),
		.tick(tick), .pattern(pattern), .anodes(anodes)
	);

	segment_sequencer sequencer (
		.CLK(CLK), .reset(reset),
		.tick(tick), .pattern(pattern), .enable(enable),
		.segments(segments), .slot_done(slot_done)
	);

endmodule

`default_nettype wire

//--- design/seg_pkg.sv
/* shared constants for the seven-segment display driver
   register map, response codes and the hex pattern table used by RTL and testbench */
`default_nettype none

package seg_pkg;

	localparam int seg_count = 7; // segments a..g per digit
	localparam int slot_count = 8; // token ticks per digit, last one dark
	localparam logic [seg_count-1:0] seg_blank = 7'b1111111; // active low, all off

	localparam logic [3:0] addr_digits = 4'h0; // packed nibbles, digit 0 in bits 3:0
	localparam logic [3:0] addr_control = 4'h4; // bit 0 is display enable
	localparam logic [3:0] addr_push = 4'h8; // shift-in of wdata[3:0]

	localparam logic [1:0] resp_okay = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	// active low pattern, segment a in the msb
	function automatic logic [seg_count-1:0] hex_to_segments(input logic [3:0] value);
		case (value)
			4'h0: return 7'b0000001;
			4'h1: return 7'b1001111;
			4'h2: return 7'b0010010;
			4'h3: return 7'b0000110;
			4'h4: return 7'b1001100;
			4'h5: return 7'b0100100;
			4'h6: return 7'b0100000;
			4'h7: return 7'b0001111;
			4'h8: return 7'b0000000;
			4'h9: return 7'b0000100;
			4'ha: return 7'b0001000;
			4'hb: return 7'b1100000;
			4'hc: return 7'b1110010;
			4'hd: return 7'b1000010;
			4'he: return 7'b0110000;
			default: return 7'b0111000; // F
		endcase
	endfunction

endpackage

`default_nettype wire

//--- design/segment_sequencer.sv
/* segment sequencer with a rotating one-hot token
   lights at most one segment per tick and flags the end of each digit slot */
`timescale 1ns/10ps
`default_nettype none

module segment_sequencer import seg_pkg::*; (
	input  wire                   CLK,
	input  wire                   reset,
	input  wire                   tick, // advance the token
	input  wire  [seg_count-1:0]  pattern, // active low, segment a in msb
	input  wire                   enable,
	output logic [seg_count-1:0]  segments, // active low segment pins
	output logic                  slot_done // pulse on the tick leaving the dark position
);

	localparam logic [slot_count-1:0] token_start = slot_count'(1);

	// token bit i selects segment i counted from a, top bit is the dark tick
	logic [slot_count-1:0] token;

	always_ff @(posedge CLK) begin
		if (reset) begin
			token <= token_start; // position 0, segment a
		end else begin
			if (tick) begin
				token <= {token[slot_count-2:0], token[slot_count-1]}; // rotate left
			end
		end
	end

	assign slot_done = tick && token[slot_count-1];

	// the pattern bit for the token position decides whether that one segment is lit
	always_comb begin
		segments = seg_blank;
		if (enable) begin
			for (int i = 0; i < seg_count; i++) begin
				if (token[i] && !pattern[seg_count-1-i]) begin
					segments[seg_count-1-i] = 1'b0; // drive low to light
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- sim.f
design/seg_pkg.sv
design/axil_display_regs.sv
design/digit_scanner.sv
design/segment_sequencer.sv
design/seg_display_top.sv
verification/seg_display_checker.sv
verification/seg_display_tb.sv

//--- verification/seg_display_checker.sv
/* concurrent checks on the digit scanner outputs
   attached to every digit_scanner instance through the bind at the end of this file */
`timescale 1ns/10ps
`default_nettype none

module seg_display_checker import seg_pkg::*; #(
	parameter int num_digits = 4
) (
	input  wire                     CLK,
	input  wire                     reset,
	input  wire                     enable,
	input  wire                     slot_done,
	input  wire  [seg_count-1:0]    pattern, // latched active low pattern
	input  wire  [num_digits-1:0]   anodes
);

	int unsigned failures = 0; // failed assertions so far

	// never more than one digit driven
	anodes_one_hot: assert property (@(posedge CLK) disable iff (reset)
		$onehot0(anodes))
		else begin
			failures++;
			$error("anodes are neither zero nor one-hot");
		end

	// display off means no anode at all
	anodes_dark_when_off: assert property (@(posedge CLK) disable iff (reset)
		!enable |-> (anodes == '0))
		else begin
			failures++;
			$error("anode driven while enable is low");
		end

	// pattern only moves on the edge after a slot end
	pattern_steady: assert property (@(posedge CLK) disable iff (reset)
		!slot_done |=> $stable(pattern))
		else begin
			failures++;
			$error("pattern changed inside a digit slot");
		end

endmodule

bind digit_scanner seg_display_checker #(.num_digits(num_digits)) scan_checks (
	.CLK(CLK),
	.reset(reset),
	.enable(enable),
	.slot_done(slot_done),
	.pattern(pattern),
	.anodes(anodes)
);

`default_nettype wire

//--- verification/seg_display_tb.sv
/* testbench for the AXI4-Lite seven-segment display driver
   random register traffic and pushes against a model, then scans the pins for the digits */
`timescale 1ns/10ps
`default_nettype none

module seg_display_tb import seg_pkg::*; ();

	localparam int num_digits = 4;
	localparam int tick_log2 = 2; // short frames
	localparam int slot_cycles = slot_count * (1 << tick_log2);
	localparam int frame_cycles = num_digits * slot_cycles; // whole scan of all digits
	localparam int handshake_limit = 64; // cycles allowed per bus wait
	localparam int reg_rounds = 24;
	localparam int push_rounds = 16;
	localparam int display_rounds = 3;

	logic                    CLK = 1'b0;
	logic                    reset;
	logic [3:0]              awaddr;
	logic                    awvalid;
	logic                    awready;
	logic [31:0]             wdata;
	logic [3:0]              wstrb;
	logic                    wvalid;
	logic                    wready;
	logic [1:0]              bresp;
	logic                    bvalid;
	logic                    bready;
	logic [3:0]              araddr;
	logic                    arvalid;
	logic                    arready;
	logic [31:0]             rdata;
	logic [1:0]              rresp;
	logic                    rvalid;
	logic                    rready;
	logic [num_digits-1:0]   anodes;
	logic [seg_count-1:0]    segments;

	integer                  seed = 32'hadc4_219f;
	logic [4*num_digits-1:0] model_digits; // expected digit register
	logic                    model_enable;
	logic                    content_check_on; // compare lit segments with the model
	logic                    dark_check_on; // expect a blank display
	logic [seg_count-1:0]    seen [num_digits]; // segments observed lit per digit

	always #5 CLK = ~CLK;

	seg_display_top #(.num_digits(num_digits), .tick_log2(tick_log2)) UUT (
		.CLK(CLK), .reset(reset),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.anodes(anodes), .segments(segments)
	);

	task automatic stop_with_fail();
		$display(">>> FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("MISMATCH at time %0d ns: %s, got 0x%0h, expected 0x%0h",
				$time, what, actual, expected);
			stop_with_fail();
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timeout at time %0d ns: %s did not happen within %0d cycles",
			$time, what, handshake_limit);
		stop_with_fail();
	endtask

	// drive on the rising edge, look at ready and valid on the falling edge
	task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		int waited;
		bit done;
		@(posedge CLK);
		awaddr <= addr;
		wdata <= data;
		wstrb <= 4'hf;
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		bready <= 1'b1;
		waited = 0;
		done = 1'b0;
		while (!done) begin
			@(negedge CLK);
			if (awready && wready) begin
				done = 1'b1; // accepted on the coming edge
			end else begin
				waited++;
				if (waited >= handshake_limit) report_timeout("write address and data handshake");
			end
			@(posedge CLK);
		end
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		waited = 0;
		done = 1'b0;
		while (!done) begin
			@(negedge CLK);
			if (bvalid) begin
				done = 1'b1;
				resp = bresp;
			end else begin
				waited++;
				if (waited >= handshake_limit) report_timeout("write response");
			end
			@(posedge CLK);
		end
		bready <= 1'b0;
	endtask

	task automatic read_reg(input logic [3:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		int waited;
		bit done;
		@(posedge CLK);
		araddr <= addr;
		arvalid <= 1'b1;
		rready <= 1'b1;
		waited = 0;
		done = 1'b0;
		while (!done) begin
			@(negedge CLK);
			if (arready) begin
				done = 1'b1;
			end else begin
				waited++;
				if (waited >= handshake_limit) report_timeout("read address handshake");
			end
			@(posedge CLK);
		end
		arvalid <= 1'b0;
		waited = 0;
		done = 1'b0;
		while (!done) begin
			@(negedge CLK);
			if (rvalid) begin
				done = 1'b1;
				data = rdata; // held with rvalid
				resp = rresp;
			end else begin
				waited++;
				if (waited >= handshake_limit) report_timeout("read data");
			end
			@(posedge CLK);
		end
		rready <= 1'b0;
	endtask

	task automatic write_expect(input logic [3:0] addr, input logic [31:0] data,
			input logic [1:0] exp_resp);
		logic [1:0] resp;
		write_reg(addr, data, resp);
		check_value(resp, exp_resp, $sformatf("bresp for write to 0x%0h", addr));
	endtask

	task automatic read_expect(input logic [3:0] addr, input logic [31:0] exp_data,
			input logic [1:0] exp_resp);
		logic [31:0] data;
		logic [1:0] resp;
		read_reg(addr, data, resp);
		check_value(resp, exp_resp, $sformatf("rresp at offset 0x%0h", addr));
		check_value(data, exp_data, $sformatf("rdata at offset 0x%0h", addr));
	endtask

	task automatic compare_registers();
		read_expect(addr_digits, model_digits, resp_okay); // zero extended
		read_expect(addr_control, model_enable, resp_okay);
	endtask

	task automatic wait_cycles(input int count);
		repeat (count) @(posedge CLK);
	endtask

	task automatic clear_seen();
		for (int k = 0; k < num_digits; k++) begin
			seen[k] = '0;
		end
	endtask

	// every segment a digit needs must have shown up during the watched frame
	task automatic check_all_lit();
		logic [seg_count-1:0] expected;
		for (int k = 0; k < num_digits; k++) begin
			expected = hex_to_segments(model_digits[4*k +: 4]);
			for (int b = 0; b < seg_count; b++) begin
				if (!expected[b]) begin
					check_value(seen[k][b], 1'b1,
						$sformatf("digit %0d segment bit %0d never lit", k, b));
				end
			end
		end
	endtask

	task automatic verify_display();
		wait_cycles(frame_cycles); // every slot has latched the current digits
		clear_seen();
		content_check_on = 1'b1;
		wait_cycles(frame_cycles);
		content_check_on = 1'b0;
		check_all_lit();
	endtask

	task automatic verify_dark();
		wait_cycles(frame_cycles);
		dark_check_on = 1'b1;
		wait_cycles(frame_cycles);
		dark_check_on = 1'b0;
	endtask

	// pin checks on the falling edge where the outputs have settled
	always @(negedge CLK) begin : sample_outputs
		logic [seg_count-1:0] expected;
		if (reset === 1'b0) begin
			check_value($onehot0(anodes), 1'b1, "anodes neither zero nor one-hot");
			check_value(($countones(~segments) <= 1), 1'b1, "more than one segment lit");
			if (dark_check_on) begin
				check_value(anodes, '0, "anode driven while disabled");
				check_value(segments, seg_blank, "segment lit while disabled");
			end
			if (content_check_on) begin
				for (int k = 0; k < num_digits; k++) begin
					if (anodes[k]) begin
						expected = hex_to_segments(model_digits[4*k +: 4]);
						for (int b = 0; b < seg_count; b++) begin
							if (!segments[b]) begin
								check_value(expected[b], 1'b0,
									$sformatf("digit %0d segment bit %0d lit", k, b));
								seen[k][b] = 1'b1;
							end
						end
					end
				end
			end
		end
	end

	// the bound scanner checker counts its failed assertions
	always @(UUT.scanner.scan_checks.failures) begin : watch_checker
		if (UUT.scanner.scan_checks.failures != 0) begin
			$display("assertion failure in the scanner checker at time %0d ns", $time);
			stop_with_fail();
		end
	end

	initial begin : stimulus
		logic [31:0] rnd;
		logic [31:0] data;
		logic [31:0] got;
		logic [1:0]  resp;
		logic [3:0]  bad_addr;
		reset <= 1'b1;
		awaddr <= '0;
		awvalid <= 1'b0;
		wdata <= '0;
		wstrb <= '0;
		wvalid <= 1'b0;
		bready <= 1'b0;
		araddr <= '0;
		arvalid <= 1'b0;
		rready <= 1'b0;
		model_digits = '0;
		model_enable = 1'b0;
		content_check_on = 1'b0;
		dark_check_on = 1'b0;
		repeat (10) @(posedge CLK);
		reset <= 1'b0;
		compare_registers(); // reset values

		// random writes with readback, plus push reads and unmapped offsets
		for (int i = 0; i < reg_rounds; i++) begin
			rnd = $random(seed);
			data = $random(seed);
			if (rnd[0]) begin
				write_expect(addr_digits, data, resp_okay);
				model_digits = data[4*num_digits-1:0];
			end else begin
				write_expect(addr_control, data, resp_okay);
				model_enable = data[0];
			end
			compare_registers();
			if (rnd[1]) read_expect(addr_push, '0, resp_okay);
			if (rnd[2]) begin
				bad_addr = {rnd[5:4], 2'b01}; // 1, 5, 9 or d
				write_expect(bad_addr, $random(seed), resp_slverr);
				read_reg(bad_addr, got, resp);
				check_value(resp, resp_slverr, "rresp for an unmapped offset");
				compare_registers(); // nothing may have changed
			end
		end

		// shift-in, new nibble enters at digit 0
		for (int i = 0; i < push_rounds; i++) begin
			data = $random(seed);
			write_expect(addr_push, data, resp_okay);
			model_digits = {model_digits[4*num_digits-5:0], data[3:0]};
			read_expect(addr_digits, model_digits, resp_okay);
		end

		write_expect(addr_control, 32'h1, resp_okay);
		model_enable = 1'b1;
		verify_display(); // digits left by the pushes
		for (int r = 0; r < display_rounds; r++) begin
			data = $random(seed);
			write_expect(addr_digits, data, resp_okay);
			model_digits = data[4*num_digits-1:0];
			verify_display();
		end

		// blank while off, then the same digits again
		write_expect(addr_control, 32'h0, resp_okay);
		model_enable = 1'b0;
		verify_dark();
		write_expect(addr_control, 32'h1, resp_okay);
		model_enable = 1'b1;
		verify_display();
		@(negedge CLK);

		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire
